// File: common/vic_pkg.sv
`default_nettype none

package vic_pkg;

        // bus byte and register address
        typedef logic [7:0] data_t;
        typedef logic [5:0] reg_addr_t;

        // palette index, fine scroll and raster line
        typedef logic [3:0] color_t;
        typedef logic [2:0] scroll_t;
        typedef logic [8:0] raster_t;

        // memory setup fields
        typedef logic [2:0] cb_t;
        typedef logic [3:0] vm_t;

        // screen and raster registers
        localparam reg_addr_t reg_screen_control_1 = 6'h11;
        localparam reg_addr_t reg_raster_line = 6'h12;
        localparam reg_addr_t reg_screen_control_2 = 6'h16;
        localparam reg_addr_t reg_memory_setup = 6'h18;

        // interrupt registers
        localparam reg_addr_t reg_interrupt_status = 6'h19;
        localparam reg_addr_t reg_interrupt_control = 6'h1a;

        // colors
        localparam reg_addr_t reg_border_color = 6'h20;
        localparam reg_addr_t reg_background_color_0 = 6'h21;
        localparam reg_addr_t reg_background_color_1 = 6'h22;
        localparam reg_addr_t reg_background_color_2 = 6'h23;
        localparam reg_addr_t reg_background_color_3 = 6'h24;

        // read value when no block claims the address
        localparam data_t unmapped_data = 8'hff;

        // progress of one access within a phi cycle
        typedef enum logic [1:0] {
                bus_idle,
                bus_latched,
                bus_done
        } bus_state_e;

endpackage

`default_nettype wire

// File: source/bus_access.sv
`timescale 1ns/1ns
`default_nettype none

module bus_access (
        input  wire                      clk_dot4x,
        input  wire                      rst,
        input  wire                      clk_phi,
        input  wire                      phi_phase_start_1,
        input  wire                      phi_phase_start_dav,
        input  wire                      ras,
        input  wire                      ce,
        input  wire                      rw,
        input  wire                      aec,
        input  wire vic_pkg::reg_addr_t  adi,
        input  wire vic_pkg::data_t      vid_rd_data,
        input  wire                      vid_rd_hit,
        input  wire vic_pkg::data_t      irq_rd_data,
        input  wire                      irq_rd_hit,
        output vic_pkg::reg_addr_t       addr,
        output logic                     rd_stb,
        output logic                     wr_stb,
        output vic_pkg::data_t           dbo
);
        import vic_pkg::*;

        bus_state_e state;
        logic       latch_now;
        logic       bus_owned;

        // address phase: high half of phi with ras low
        assign latch_now = (state == bus_idle) && clk_phi && !ras;
        assign bus_owned = aec && !ce;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        state  <= bus_idle;
                        rd_stb <= 1'b0;
                        wr_stb <= 1'b0;
                end else begin
                        rd_stb <= 1'b0;
                        wr_stb <= 1'b0;
                        case (state)
                        bus_idle: begin
                                if (latch_now) begin
                                        state <= bus_latched;
                                end
                        end
                        bus_latched: begin
                                if (phi_phase_start_1) begin
                                        state <= bus_idle;
                                end else if (bus_owned) begin
                                        // a read happens once, then waits out the phase
                                        if (rw) begin
                                                rd_stb <= 1'b1;
                                                state  <= bus_done;
                                        end else if (phi_phase_start_dav) begin
                                                wr_stb <= 1'b1;
                                        end
                                end
                        end
                        default: begin
                                if (phi_phase_start_1) begin
                                        state <= bus_idle;
                                end
                        end
                        endcase
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (latch_now) begin
                        addr <= adi;
                end
        end

        // read data lands one edge after rd_stb
        always_ff @(posedge clk_dot4x) begin
                if (rd_stb) begin
                        if (vid_rd_hit) begin
                                dbo <= vid_rd_data;
                        end else if (irq_rd_hit) begin
                                dbo <= irq_rd_data;
                        end else begin
                                dbo <= unmapped_data;
                        end
                end
        end

        // rw decides the access kind for the whole phase
        strobes_exclusive: assert property (@(posedge clk_dot4x) disable iff (rst)
                !(rd_stb && wr_stb));

endmodule

`default_nettype wire

// File: regs/video_control_regs.sv
`timescale 1ns/1ns
`default_nettype none

module video_control_regs (
        input  wire                      clk_dot4x,
        input  wire vic_pkg::reg_addr_t  addr,
        input  wire                      wr_stb,
        input  wire vic_pkg::data_t      wr_data,
        input  wire vic_pkg::raster_t    raster_line,
        output vic_pkg::data_t           rd_data,
        output logic                     rd_hit,
        output vic_pkg::color_t          ec,
        output vic_pkg::color_t          b0c,
        output vic_pkg::color_t          b1c,
        output vic_pkg::color_t          b2c,
        output vic_pkg::color_t          b3c,
        output vic_pkg::scroll_t         xscroll,
        output vic_pkg::scroll_t         yscroll,
        output logic                     csel,
        output logic                     rsel,
        output logic                     den,
        output logic                     bmm,
        output logic                     ecm,
        output logic                     mcm,
        output vic_pkg::raster_t         raster_irq_compare,
        output vic_pkg::cb_t             cb,
        output vic_pkg::vm_t             vm
);
        import vic_pkg::*;

        // unused mode bit, kept only for readback
        logic res;

        always_ff @(posedge clk_dot4x) begin
                if (wr_stb) begin
                        case (addr)
                        reg_screen_control_1: begin
                                yscroll <= wr_data[2:0];
                                rsel <= wr_data[3];
                                den <= wr_data[4];
                                bmm <= wr_data[5];
                                ecm <= wr_data[6];
                                raster_irq_compare[8] <= wr_data[7];
                        end
                        reg_raster_line: begin
                                raster_irq_compare[7:0] <= wr_data;
                        end
                        reg_screen_control_2: begin
                                xscroll <= wr_data[2:0];
                                csel <= wr_data[3];
                                mcm <= wr_data[4];
                                res <= wr_data[5];
                        end
                        reg_memory_setup: begin
                                cb <= wr_data[3:1];
                                vm <= wr_data[7:4];
                        end
                        // colors keep the low nibble
                        reg_border_color: ec <= wr_data[3:0];
                        reg_background_color_0: b0c <= wr_data[3:0];
                        reg_background_color_1: b1c <= wr_data[3:0];
                        reg_background_color_2: b2c <= wr_data[3:0];
                        reg_background_color_3: b3c <= wr_data[3:0];
                        default: begin
                        end
                        endcase
                end
        end

        // readback, unused bits read as 1
        always_comb begin
                rd_hit  = 1'b1;
                rd_data = unmapped_data;
                case (addr)
                reg_screen_control_1: begin
                        // bit 7 shows the current line, not the compare value
                        rd_data = {raster_line[8], ecm, bmm, den, rsel, yscroll};
                end
                reg_raster_line: begin
                        rd_data = raster_line[7:0];
                end
                reg_screen_control_2: begin
                        rd_data = {2'b11, res, mcm, csel, xscroll};
                end
                reg_memory_setup: begin
                        rd_data = {vm, cb, 1'b1};
                end
                reg_border_color: rd_data = {4'hf, ec};
                reg_background_color_0: rd_data = {4'hf, b0c};
                reg_background_color_1: rd_data = {4'hf, b1c};
                reg_background_color_2: rd_data = {4'hf, b2c};
                reg_background_color_3: rd_data = {4'hf, b3c};
                default: begin
                        rd_hit = 1'b0;
                end
                endcase
        end

endmodule

`default_nettype wire

// File: regs/irq_regs.sv
`timescale 1ns/1ns
`default_nettype none

module irq_regs (
        input  wire                      clk_dot4x,
        input  wire                      rst,
        input  wire                      clk_phi,
        input  wire                      phi_phase_start_1,
        input  wire vic_pkg::reg_addr_t  addr,
        input  wire                      wr_stb,
        input  wire vic_pkg::data_t      wr_data,
        input  wire                      irq,
        input  wire                      ilp,
        input  wire                      immc,
        input  wire                      imbc,
        input  wire                      irst,
        output vic_pkg::data_t           rd_data,
        output logic                     rd_hit,
        output logic                     erst,
        output logic                     embc,
        output logic                     emmc,
        output logic                     elp,
        output logic                     irst_clr,
        output logic                     imbc_clr,
        output logic                     immc_clr,
        output logic                     ilp_clr
);
        import vic_pkg::*;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        {elp, emmc, embc, erst} <= 4'b0000;
                        {ilp_clr, immc_clr, imbc_clr, irst_clr} <= 4'b0000;
                end else begin
                        // acks live until the interrupt block has sampled them
                        if (phi_phase_start_1 && !clk_phi) begin
                                {ilp_clr, immc_clr, imbc_clr, irst_clr} <= 4'b0000;
                        end
                        if (wr_stb && addr == reg_interrupt_status) begin
                                {ilp_clr, immc_clr, imbc_clr, irst_clr} <= wr_data[3:0];
                        end
                        if (wr_stb && addr == reg_interrupt_control) begin
                                {elp, emmc, embc, erst} <= wr_data[3:0];
                        end
                end
        end

        always_comb begin
                rd_hit  = 1'b1;
                rd_data = unmapped_data;
                case (addr)
                // irq arrives already inverted
                reg_interrupt_status: rd_data = {irq, 3'b111, ilp, immc, imbc, irst};
                reg_interrupt_control: rd_data = {4'hf, elp, emmc, embc, erst};
                default: rd_hit = 1'b0;
                endcase
        end

        // acks stay low for as long as reset is held
        ack_clear_in_reset: assert property (@(posedge clk_dot4x)
                rst |-> !(irst_clr || imbc_clr || immc_clr || ilp_clr));

endmodule

`default_nettype wire

// File: source/vic_registers.sv
`timescale 1ns/1ns
`default_nettype none

module vic_registers (
        input  wire                      clk_dot4x,
        input  wire                      rst,
        input  wire                      clk_phi,
        input  wire                      phi_phase_start_1,
        input  wire                      phi_phase_start_dav,
        input  wire                      ras,
        input  wire                      ce,
        input  wire                      rw,
        input  wire                      aec,
        input  wire vic_pkg::reg_addr_t  adi,
        input  wire vic_pkg::data_t      dbi,
        input  wire vic_pkg::raster_t    raster_line,
        input  wire                      irq,
        input  wire                      ilp,
        input  wire                      immc,
        input  wire                      imbc,
        input  wire                      irst,
        output wire vic_pkg::data_t      dbo,
        output wire vic_pkg::color_t     ec, b0c, b1c, b2c, b3c,
        output wire vic_pkg::scroll_t    xscroll, yscroll,
        output wire                      csel, rsel, den, bmm, ecm, mcm,
        output wire vic_pkg::raster_t    raster_irq_compare,
        output wire vic_pkg::cb_t        cb,
        output wire vic_pkg::vm_t        vm,
        output wire                      irst_clr, imbc_clr, immc_clr, ilp_clr,
        output wire                      erst, embc, emmc, elp
);
        import vic_pkg::*;

        reg_addr_t addr;
        logic      wr_stb;
        data_t     vid_rd_data;
        logic      vid_rd_hit;
        data_t     irq_rd_data;
        logic      irq_rd_hit;

        // no register left here has a read side effect, so rd_stb stays open
        bus_access bus_access_i (
                .*,
                .rd_stb ()
        );

        video_control_regs video_control_regs_i (
                .*,
                .wr_data (dbi),
                .rd_data (vid_rd_data),
                .rd_hit  (vid_rd_hit)
        );

        irq_regs irq_regs_i (
                .*,
                .wr_data (dbi),
                .rd_data (irq_rd_data),
                .rd_hit  (irq_rd_hit)
        );

endmodule

`default_nettype wire

// File: test/tb_vic_registers.sv
`timescale 1ns/1ns
`default_nettype none

module tb_vic_registers;
        import vic_pkg::*;

        localparam int phase_clocks = 16;
        localparam int max_lines = 64;

        logic clk_dot4x, rst, clk_phi, phi_phase_start_1, phi_phase_start_dav;
        logic ras, ce, rw, aec;
        reg_addr_t adi;
        data_t dbi;
        raster_t raster_line;
        logic irq, ilp, immc, imbc, irst;
        data_t dbo;
        color_t ec, b0c, b1c, b2c, b3c;
        scroll_t xscroll, yscroll;
        logic csel, rsel, den, bmm, ecm, mcm;
        raster_t raster_irq_compare;
        cb_t cb;
        vm_t vm;
        logic irst_clr, imbc_clr, immc_clr, ilp_clr;
        logic erst, embc, emmc, elp;

        // bytes written over the bus for each register address
        data_t model [0:63];
        logic known [0:63];
        logic [3:0] ack_expect = 4'b0000;
        string color_names [5] = '{"ec", "b0c", "b1c", "b2c", "b3c"};

        logic pat_write [max_lines];
        reg_addr_t pat_addr [max_lines];
        data_t pat_data [max_lines];
        int pat_raster [max_lines];
        int pat_status [max_lines];
        data_t pat_exp [max_lines];
        int num_lines = 0;
        logic patterns_loaded = 1'b0;
        int errors = 0;
        int checks = 0;

        vic_registers vic_registers_i (.*);

        initial begin
                clk_dot4x = 1'b0;
                forever #20 clk_dot4x = !clk_dot4x;
        end

        task automatic compare_data(input string name, input data_t got, input data_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
                end
        endtask

        task automatic compare_color(input string name, input color_t got, input color_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
                end
        endtask

        task automatic compare_raster(input string name, input raster_t got, input raster_t exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
                end
        endtask

        task automatic compare_bit(input string name, input logic got, input logic exp);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
                end
        endtask

        task automatic check_acks(input logic [3:0] exp);
                compare_bit("ilp_clr", ilp_clr, exp[3]);
                compare_bit("immc_clr", immc_clr, exp[2]);
                compare_bit("imbc_clr", imbc_clr, exp[1]);
                compare_bit("irst_clr", irst_clr, exp[0]);
        endtask

        // outputs follow the bit layout of the last write to each register
        task automatic check_outputs;
                data_t sc1;
                data_t sc2;
                data_t mem;
                data_t ctl;
                color_t colors [5];
                int k;
                int idx;
                sc1 = model[reg_screen_control_1];
                sc2 = model[reg_screen_control_2];
                mem = model[reg_memory_setup];
                ctl = model[reg_interrupt_control];
                colors = '{ec, b0c, b1c, b2c, b3c};
                for (k = 0; k < 5; k++) begin
                        idx = int'(reg_border_color) + k;
                        if (known[idx]) begin
                                compare_color(color_names[k], colors[k], model[idx][3:0]);
                        end
                end
                if (known[reg_screen_control_1]) begin
                        compare_data("yscroll", {5'b00000, yscroll}, {5'b00000, sc1[2:0]});
                        compare_bit("rsel", rsel, sc1[3]);
                        compare_bit("den", den, sc1[4]);
                        compare_bit("bmm", bmm, sc1[5]);
                        compare_bit("ecm", ecm, sc1[6]);
                end
                if (known[reg_screen_control_1] && known[reg_raster_line]) begin
                        compare_raster("raster_irq_compare", raster_irq_compare,
                                {sc1[7], model[reg_raster_line]});
                end
                if (known[reg_screen_control_2]) begin
                        compare_data("xscroll", {5'b00000, xscroll}, {5'b00000, sc2[2:0]});
                        compare_bit("csel", csel, sc2[3]);
                        compare_bit("mcm", mcm, sc2[4]);
                end
                if (known[reg_memory_setup]) begin
                        compare_data("cb", {5'b00000, cb}, {5'b00000, mem[3:1]});
                        compare_data("vm", {4'h0, vm}, {4'h0, mem[7:4]});
                end
                compare_bit("erst", erst, ctl[0]);
                compare_bit("embc", embc, ctl[1]);
                compare_bit("emmc", emmc, ctl[2]);
                compare_bit("elp", elp, ctl[3]);
        endtask

        // dbo for reads whose inputs were random
        function automatic data_t expected_read(input reg_addr_t a, input data_t file_exp);
                case (a)
                reg_screen_control_1: return {raster_line[8], model[reg_screen_control_1][6:0]};
                reg_raster_line: return raster_line[7:0];
                reg_interrupt_status: return {irq, 3'b111, ilp, immc, imbc, irst};
                default: return file_exp;
                endcase
        endfunction

        // one phi cycle with the low half at clocks 0 to 7 and the high half at 8 to 15
        task automatic run_phase(input logic access, input logic write_op, input reg_addr_t a,
                        input data_t d);
                int i;
                for (i = 0; i < phase_clocks; i++) begin
                        @(posedge clk_dot4x);
                        #2;
                        if (i == 0) begin
                                rw = !write_op;
                                adi = a;
                                dbi = d;
                        end
                        // clk_phi as the core sees it trails the phase strobes by one clock
                        clk_phi = (i >= 9) || (i == 0);
                        phi_phase_start_1 = (i == 0) || (i == 8);
                        phi_phase_start_dav = (i == 13);
                        ras = !(access && i >= 8);
                        ce = !(access && i >= 8);
                        aec = (i >= 8);
                        if (i == 4) begin
                                check_acks(ack_expect);
                        end
                        if (i == 12) begin
                                check_acks(4'b0000);
                        end
                end
                // the write landed at the end of clock 14
                if (access && write_op) begin
                        model[a] = d;
                        known[a] = 1'b1;
                end
                ack_expect = (access && write_op && a == reg_interrupt_status) ? d[3:0] : 4'b0000;
                check_outputs();
        endtask

        initial begin
                wait (patterns_loaded);
                repeat (num_lines * phase_clocks + 100) @(posedge clk_dot4x);
                $display("timeout: the patterns did not complete in the expected number of clocks");
                $display("*** FAILED ***");
                $finish;
        end

        initial begin
                int fd;
                int n;
                int ln;
                string text;
                logic [7:0] op_c;
                int a, d, r, s, e;
                data_t exp;
                logic randomized;
                void'($urandom(55));
                rst = 1'b1;
                clk_phi = 1'b0;
                phi_phase_start_1 = 1'b0;
                phi_phase_start_dav = 1'b0;
                ras = 1'b1;
                ce = 1'b1;
                rw = 1'b1;
                aec = 1'b0;
                adi = '0;
                dbi = '0;
                raster_line = '0;
                {irq, ilp, immc, imbc, irst} = 5'b00000;
                for (n = 0; n < 64; n++) begin
                        model[n] = 8'h00;
                        known[n] = 1'b0;
                end
                // enables come out of reset cleared
                known[reg_interrupt_control] = 1'b1;

                fd = $fopen("test/vic_patterns.txt", "r");
                if (fd == 0) begin
                        $display("error: cannot open test/vic_patterns.txt");
                        errors++;
                end else begin
                        while (!$feof(fd) && num_lines < max_lines) begin
                                n = $fgets(text, fd);
                                if (n > 0 && text[0] != "#") begin
                                        n = $sscanf(text, "%c %h %h %h %h %h", op_c, a, d, r, s, e);
                                        if (n == 6) begin
                                                pat_write[num_lines] = (op_c == "W");
                                                pat_addr[num_lines] = reg_addr_t'(a);
                                                pat_data[num_lines] = data_t'(d);
                                                pat_raster[num_lines] = r;
                                                pat_status[num_lines] = s;
                                                pat_exp[num_lines] = data_t'(e);
                                                num_lines++;
                                        end
                                end
                        end
                        $fclose(fd);
                        if (num_lines == 0) begin
                                $display("error: no pattern lines found in the stimulus file");
                                errors++;
                        end
                end
                patterns_loaded = 1'b1;

                repeat (3) @(posedge clk_dot4x);
                #2;
                rst = 1'b0;

                for (ln = 0; ln < num_lines; ln++) begin
                        randomized = 1'b0;
                        if (pat_raster[ln] == 'h1ff) begin
                                raster_line = raster_t'($urandom);
                                randomized = 1'b1;
                        end else begin
                                raster_line = raster_t'(pat_raster[ln]);
                        end
                        if (pat_status[ln] == 'h1ff) begin
                                {irq, ilp, immc, imbc, irst} = 5'($urandom);
                                randomized = 1'b1;
                        end else begin
                                {irq, ilp, immc, imbc, irst} = 5'(pat_status[ln]);
                        end
                        run_phase(1'b1, pat_write[ln], pat_addr[ln], pat_data[ln]);
                        if (!pat_write[ln]) begin
                                exp = randomized ? expected_read(pat_addr[ln], pat_exp[ln])
                                        : pat_exp[ln];
                                compare_data("dbo", dbo, exp);
                        end
                end
                // idle phase so the last acknowledge pulses get checked
                run_phase(1'b0, 1'b0, '0, '0);

                $display("errors: %0d in %0d checks", errors, checks);
                if (errors == 0) begin
                        $display("*** PASSED ***");
                end else begin
                        $display("*** FAILED ***");
                end
                $finish;
        end

endmodule

`default_nettype wire

// File: all.f
common/vic_pkg.sv
source/bus_access.sv
regs/video_control_regs.sv
regs/irq_regs.sv
source/vic_registers.sv
test/tb_vic_registers.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run from the project root, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_vic_registers -f all.f \
        > sim.log 2>&1 &&
        ./obj_dir/Vtb_vic_registers >> sim.log 2>&1 ||
        { echo "build or simulation did not complete, see sim.log"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log &&
        { echo "simulation failed, see sim.log"; exit 1; } ||
        echo "simulation passed"

// File: test/vic_patterns.txt
# op addr data raster status exp, in hex; status is {irq, ilp, immc, imbc, irst}
# raster or status 1ff means random, exp is the dbo of a read and unused on a write
R 1a 00 000 00 f0
W 20 a5 000 00 00
R 20 00 000 00 f5
W 21 3c 000 00 00
R 21 00 000 00 fc
W 22 07 000 00 00
R 22 00 000 00 f7
W 23 e9 000 00 00
R 23 00 000 00 f9
W 24 12 000 00 00
R 24 00 000 00 f2
W 11 9b 000 00 00
W 12 37 000 00 00
R 11 00 0c2 00 1b
R 12 00 0c2 00 c2
R 11 00 1ff 00 00
R 12 00 1ff 00 00
W 11 64 000 00 00
R 11 00 155 00 e4
W 16 f5 000 00 00
R 16 00 000 00 f5
W 16 08 000 00 00
R 16 00 000 00 c8
W 18 a6 000 00 00
R 18 00 000 00 a7
W 1a 0b 000 00 00
R 1a 00 000 00 fb
R 19 00 000 15 f5
R 19 00 000 0a 7a
R 19 00 000 1ff 00
W 19 0f 000 00 00
W 19 05 000 00 00
R 20 00 000 00 f5
W 19 fa 000 00 00
W 03 ff 000 00 00
W 15 ff 000 00 00
W 1e 00 000 00 00
W 13 55 000 00 00
W 27 0f 000 00 00
W 3f ff 000 00 00
R 00 00 000 00 ff
R 13 00 000 00 ff
R 15 00 000 00 ff
R 1c 00 000 00 ff
R 1e 00 000 00 ff
R 2f 00 000 00 ff
R 3f 00 000 00 ff
R 21 00 000 00 fc
